//--- verilog/rename_pkg.sv
/* Widths and depths shared by the rename core RTL and its testbench.
   Modules import it in their bodies and use scoped names in their port lists. */
`default_nettype none

package rename_pkg;

    // Architectural register file
    localparam int DATA_WIDTH       = 32;
    localparam int REGMAP_DEPTH     = 32;
    localparam int REGMAP_IDX_WIDTH = $clog2(REGMAP_DEPTH);

    // Reorder buffer, one tag per entry
    localparam int ROB_DEPTH        = 16;
    localparam int ROB_IDX_WIDTH    = $clog2(ROB_DEPTH);

    // Source operands looked up per dispatched instruction
    localparam int LOOKUP_PORTS     = 2;

endpackage

`default_nettype wire

//--- verilog/regmap_retire_if.sv
/* Retire bus from the reorder buffer to the register map.
   The reorder buffer drives the rob side, the register map listens on the regmap side. */
`timescale 1ns/1ps
`default_nettype none

interface regmap_retire_if;
    import rename_pkg::*;

    // Strobe for one retirement, the rest is valid only while it is high
    logic                        retire_en;
    logic [DATA_WIDTH-1:0]       retire_data;
    logic [ROB_IDX_WIDTH-1:0]    retire_tag;
    logic [REGMAP_IDX_WIDTH-1:0] retire_rdest;

    modport rob (
        output retire_en,
        output retire_data,
        output retire_tag,
        output retire_rdest
    );

    modport regmap (
        input  retire_en,
        input  retire_data,
        input  retire_tag,
        input  retire_rdest
    );

endinterface

`default_nettype wire

//--- verilog/regmap_entry.sv
/* One architectural register with committed data, rename tag and ready bit.
   The register map gives it already decoded retire and rename selects. */
`timescale 1ns/1ps
`default_nettype none

module regmap_entry (
    input  logic                                 clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_flush,

    input  logic                                 i_retire_en,
    input  logic [rename_pkg::DATA_WIDTH-1:0]    i_retire_data,
    input  logic [rename_pkg::ROB_IDX_WIDTH-1:0] i_retire_tag,

    input  logic                                 i_rename_en,
    input  logic [rename_pkg::ROB_IDX_WIDTH-1:0] i_rename_tag,

    output logic [rename_pkg::DATA_WIDTH-1:0]    o_data,
    output logic [rename_pkg::ROB_IDX_WIDTH-1:0] o_tag,
    output logic                                 o_rdy
);
    import rename_pkg::*;

    logic [DATA_WIDTH-1:0]    data_q;
    logic [ROB_IDX_WIDTH-1:0] tag_q;
    logic                     rdy_q;

    // Committed value, every retire to this register writes it
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            data_q <= '0;
        end else if (i_retire_en) begin
            data_q <= i_retire_data;
        end
    end

    // Latest producer of this register
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tag_q <= '0;
        end else if (i_rename_en) begin
            tag_q <= i_rename_tag;
        end
    end

    // A younger rename keeps the register waiting even if an older producer retires
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rdy_q <= 1'b1;
        end else if (i_flush) begin
            rdy_q <= 1'b1;
        end else if (i_rename_en) begin
            rdy_q <= 1'b0;
        end else if (i_retire_en && (i_retire_tag == tag_q)) begin
            rdy_q <= 1'b1;
        end
    end

    assign o_data = data_q;
    assign o_tag  = tag_q;
    assign o_rdy  = rdy_q;

endmodule

`default_nettype wire

//--- verilog/regmap.sv
/* Register map for renaming that holds registers 1 to 31 with tags and fixes register zero.
   Serves the source lookups of a dispatch, with a bypass from the retire bus. */
`timescale 1ns/1ps
`default_nettype none

module regmap (
    input  logic                                    clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_flush,

    regmap_retire_if.regmap                         retire,

    input  logic                                    i_rename_en,
    input  logic [rename_pkg::ROB_IDX_WIDTH-1:0]    i_rename_tag,
    input  logic [rename_pkg::REGMAP_IDX_WIDTH-1:0] i_rename_rdest,

    input  logic [rename_pkg::REGMAP_IDX_WIDTH-1:0] i_lookup_rsrc [rename_pkg::LOOKUP_PORTS],
    output logic [rename_pkg::DATA_WIDTH-1:0]       o_lookup_data [rename_pkg::LOOKUP_PORTS],
    output logic [rename_pkg::ROB_IDX_WIDTH-1:0]    o_lookup_tag  [rename_pkg::LOOKUP_PORTS],
    output logic                                    o_lookup_rdy  [rename_pkg::LOOKUP_PORTS]
);
    import rename_pkg::*;

    logic [REGMAP_DEPTH-1:1]  retire_sel;
    logic [REGMAP_DEPTH-1:1]  rename_sel;

    logic [DATA_WIDTH-1:0]    entry_data [REGMAP_DEPTH];
    logic [ROB_IDX_WIDTH-1:0] entry_tag  [REGMAP_DEPTH];
    logic [REGMAP_DEPTH-1:0]  entry_rdy;

    // One-hot selects from the retire and rename destinations
    always_comb begin
        for (int i = 1; i < REGMAP_DEPTH; i++) begin
            retire_sel[i] = retire.retire_en &&
                            (retire.retire_rdest == REGMAP_IDX_WIDTH'(i));
            rename_sel[i] = i_rename_en && (i_rename_rdest == REGMAP_IDX_WIDTH'(i));
        end
    end

    // Register zero reads as zero and is never waiting
    assign entry_data[0] = '0;
    assign entry_tag[0]  = '0;
    assign entry_rdy[0]  = 1'b1;

    for (genvar r = 1; r < REGMAP_DEPTH; r++) begin : gen_regmap_entry
        regmap_entry regmap_entry_inst (
            .clk           (clk),
            .i_rst_n       (i_rst_n),
            .i_flush       (i_flush),
            .i_retire_en   (retire_sel[r]),
            .i_retire_data (retire.retire_data),
            .i_retire_tag  (retire.retire_tag),
            .i_rename_en   (rename_sel[r]),
            .i_rename_tag  (i_rename_tag),
            .o_data        (entry_data[r]),
            .o_tag         (entry_tag[r]),
            .o_rdy         (entry_rdy[r])
        );
    end

    // Lookup with bypass of a value that retires in this cycle,
    // so a dispatch does not wait on a producer that is just leaving
    always_comb begin
        for (int i = 0; i < LOOKUP_PORTS; i++) begin
            logic                        bypass;
            logic [REGMAP_IDX_WIDTH-1:0] src;

            src    = i_lookup_rsrc[i];
            bypass = retire.retire_en &&
                     !entry_rdy[src] &&
                     (entry_tag[src] == retire.retire_tag) &&
                     (retire.retire_rdest == src);

            // A bypassed register already holds the retiring tag
            o_lookup_tag[i] = entry_tag[src];
            if (bypass) begin
                o_lookup_data[i] = retire.retire_data;
                o_lookup_rdy[i]  = 1'b1;
            end else begin
                o_lookup_data[i] = entry_data[src];
                o_lookup_rdy[i]  = entry_rdy[src];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/reorder_buffer.sv
/* Circular reorder buffer: hands out tags on dispatch, collects writebacks
   in any order and retires the oldest done entry into the register map. */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                                    clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_flush,

    input  logic                                    i_dispatch_en,
    input  logic [rename_pkg::REGMAP_IDX_WIDTH-1:0] i_dispatch_rdest,
    output logic [rename_pkg::ROB_IDX_WIDTH-1:0]    o_dispatch_tag,
    output logic                                    o_rob_full,

    input  logic                                    i_wb_en,
    input  logic [rename_pkg::ROB_IDX_WIDTH-1:0]    i_wb_tag,
    input  logic [rename_pkg::DATA_WIDTH-1:0]       i_wb_data,

    output logic                                    o_rename_en,
    output logic [rename_pkg::ROB_IDX_WIDTH-1:0]    o_rename_tag,
    output logic [rename_pkg::REGMAP_IDX_WIDTH-1:0] o_rename_rdest,

    regmap_retire_if.rob                            retire
);
    import rename_pkg::*;

    localparam int CNT_WIDTH = ROB_IDX_WIDTH + 1;

    logic [ROB_DEPTH-1:0]        rob_valid;
    logic [ROB_DEPTH-1:0]        rob_done;
    logic [REGMAP_IDX_WIDTH-1:0] rob_rdest [ROB_DEPTH];
    logic [DATA_WIDTH-1:0]       rob_data  [ROB_DEPTH];

    logic [ROB_IDX_WIDTH-1:0]    head_q;
    logic [ROB_IDX_WIDTH-1:0]    tail_q;
    logic [CNT_WIDTH-1:0]        count_q;

    logic                        full;
    logic                        dispatch_accept;
    logic                        retire_fire;

    assign full            = (count_q == CNT_WIDTH'(ROB_DEPTH));
    assign dispatch_accept = i_dispatch_en && !full && !i_flush;

    // Head leaves only once its result is back; a flush cancels it
    assign retire_fire     = rob_valid[head_q] && rob_done[head_q] && !i_flush;

    assign o_dispatch_tag  = tail_q;
    assign o_rob_full      = full;

    // Register zero gets a tag but is never renamed
    assign o_rename_en     = dispatch_accept && (i_dispatch_rdest != '0);
    assign o_rename_tag    = tail_q;
    assign o_rename_rdest  = i_dispatch_rdest;

    assign retire.retire_en    = retire_fire;
    assign retire.retire_data  = rob_data[head_q];
    assign retire.retire_tag   = head_q;
    assign retire.retire_rdest = rob_rdest[head_q];

    // Entry state bits
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rob_valid <= '0;
            rob_done  <= '0;
        end else if (i_flush) begin
            rob_valid <= '0;
            rob_done  <= '0;
        end else begin
            if (i_wb_en && rob_valid[i_wb_tag]) begin
                rob_done[i_wb_tag] <= 1'b1;
            end
            if (dispatch_accept) begin
                rob_valid[tail_q] <= 1'b1;
                rob_done[tail_q]  <= 1'b0;
            end
            if (retire_fire) begin
                rob_valid[head_q] <= 1'b0;
                rob_done[head_q]  <= 1'b0;
            end
        end
    end

    // Destination and result payload
    always_ff @(posedge clk) begin
        if (!i_flush) begin
            if (i_wb_en) begin
                rob_data[i_wb_tag] <= i_wb_data;
            end
            if (dispatch_accept) begin
                rob_rdest[tail_q] <= i_dispatch_rdest;
            end
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (dispatch_accept) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_fire) begin
                head_q <= head_q + 1'b1;
            end
            case ({dispatch_accept, retire_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/rename_core.sv
/* Top level of the rename and retire core with plain ports.
   Connects the reorder buffer to the register map over the retire bus. */
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  logic                                    clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_flush,

    input  logic                                    i_dispatch_en,
    input  logic [rename_pkg::REGMAP_IDX_WIDTH-1:0] i_dispatch_rdest,
    input  logic [rename_pkg::REGMAP_IDX_WIDTH-1:0] i_lookup_rsrc0,
    input  logic [rename_pkg::REGMAP_IDX_WIDTH-1:0] i_lookup_rsrc1,

    input  logic                                    i_wb_en,
    input  logic [rename_pkg::ROB_IDX_WIDTH-1:0]    i_wb_tag,
    input  logic [rename_pkg::DATA_WIDTH-1:0]       i_wb_data,

    output logic [rename_pkg::ROB_IDX_WIDTH-1:0]    o_dispatch_tag,
    output logic                                    o_rob_full,
    output logic [rename_pkg::DATA_WIDTH-1:0]       o_lookup_data0,
    output logic [rename_pkg::DATA_WIDTH-1:0]       o_lookup_data1,
    output logic [rename_pkg::ROB_IDX_WIDTH-1:0]    o_lookup_tag0,
    output logic [rename_pkg::ROB_IDX_WIDTH-1:0]    o_lookup_tag1,
    output logic                                    o_lookup_rdy0,
    output logic                                    o_lookup_rdy1
);
    import rename_pkg::*;

    logic                        rename_en;
    logic [ROB_IDX_WIDTH-1:0]    rename_tag;
    logic [REGMAP_IDX_WIDTH-1:0] rename_rdest;

    logic [REGMAP_IDX_WIDTH-1:0] lookup_rsrc [LOOKUP_PORTS];
    logic [DATA_WIDTH-1:0]       lookup_data [LOOKUP_PORTS];
    logic [ROB_IDX_WIDTH-1:0]    lookup_tag  [LOOKUP_PORTS];
    logic                        lookup_rdy  [LOOKUP_PORTS];

    assign lookup_rsrc[0] = i_lookup_rsrc0;
    assign lookup_rsrc[1] = i_lookup_rsrc1;

    assign o_lookup_data0 = lookup_data[0];
    assign o_lookup_data1 = lookup_data[1];
    assign o_lookup_tag0  = lookup_tag[0];
    assign o_lookup_tag1  = lookup_tag[1];
    assign o_lookup_rdy0  = lookup_rdy[0];
    assign o_lookup_rdy1  = lookup_rdy[1];

    regmap_retire_if retire_bus ();

    reorder_buffer reorder_buffer_inst (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_flush          (i_flush),
        .i_dispatch_en    (i_dispatch_en),
        .i_dispatch_rdest (i_dispatch_rdest),
        .o_dispatch_tag   (o_dispatch_tag),
        .o_rob_full       (o_rob_full),
        .i_wb_en          (i_wb_en),
        .i_wb_tag         (i_wb_tag),
        .i_wb_data        (i_wb_data),
        .o_rename_en      (rename_en),
        .o_rename_tag     (rename_tag),
        .o_rename_rdest   (rename_rdest),
        .retire           (retire_bus.rob)
    );

    regmap regmap_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_flush        (i_flush),
        .retire         (retire_bus.regmap),
        .i_rename_en    (rename_en),
        .i_rename_tag   (rename_tag),
        .i_rename_rdest (rename_rdest),
        .i_lookup_rsrc  (lookup_rsrc),
        .o_lookup_data  (lookup_data),
        .o_lookup_tag   (lookup_tag),
        .o_lookup_rdy   (lookup_rdy)
    );

endmodule

`default_nettype wire

//--- testbench/rename_core_tb.sv
/* Table-driven testbench for the rename core, checked against a reference model.
   Each table row drives one operation and compares the DUT outputs with the model. */
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;
    import rename_pkg::*;

    typedef enum logic [1:0] {OP_IDLE, OP_DISPATCH, OP_WB, OP_FLUSH} op_t;

    logic                        clk;
    logic                        i_rst_n;
    logic                        i_flush;
    logic                        i_dispatch_en;
    logic [REGMAP_IDX_WIDTH-1:0] i_dispatch_rdest;
    logic [REGMAP_IDX_WIDTH-1:0] i_lookup_rsrc0;
    logic [REGMAP_IDX_WIDTH-1:0] i_lookup_rsrc1;
    logic                        i_wb_en;
    logic [ROB_IDX_WIDTH-1:0]    i_wb_tag;
    logic [DATA_WIDTH-1:0]       i_wb_data;
    logic [ROB_IDX_WIDTH-1:0]    o_dispatch_tag;
    logic                        o_rob_full;
    logic [DATA_WIDTH-1:0]       o_lookup_data0;
    logic [DATA_WIDTH-1:0]       o_lookup_data1;
    logic [ROB_IDX_WIDTH-1:0]    o_lookup_tag0;
    logic [ROB_IDX_WIDTH-1:0]    o_lookup_tag1;
    logic                        o_lookup_rdy0;
    logic                        o_lookup_rdy1;

    // Stimulus table, one entry per cycle
    string                       row_name  [$];
    op_t                         row_op    [$];
    logic [REGMAP_IDX_WIDTH-1:0] row_rdest [$];
    logic [ROB_IDX_WIDTH-1:0]    row_tag   [$];
    logic [DATA_WIDTH-1:0]       row_data  [$];
    logic [REGMAP_IDX_WIDTH-1:0] row_src0  [$];
    logic [REGMAP_IDX_WIDTH-1:0] row_src1  [$];
    logic                        row_check [$];

    // Reference model of the register map and the in-flight entries, oldest first
    logic [DATA_WIDTH-1:0]       m_data [REGMAP_DEPTH];
    logic [ROB_IDX_WIDTH-1:0]    m_tag  [REGMAP_DEPTH];
    logic                        m_rdy  [REGMAP_DEPTH];
    logic [ROB_IDX_WIDTH-1:0]    m_tail;
    logic [ROB_IDX_WIDTH-1:0]    rob_tag   [$];
    logic [REGMAP_IDX_WIDTH-1:0] rob_rdest [$];
    logic                        rob_done  [$];
    logic [DATA_WIDTH-1:0]       rob_data  [$];

    string cur_test    = "";
    int    test_rows   = 0;
    int    test_errors = 0;
    int    tests_run   = 0;
    int    check_count = 0;
    int    error_count = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    rename_core i_dut (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_flush          (i_flush),
        .i_dispatch_en    (i_dispatch_en),
        .i_dispatch_rdest (i_dispatch_rdest),
        .i_lookup_rsrc0   (i_lookup_rsrc0),
        .i_lookup_rsrc1   (i_lookup_rsrc1),
        .i_wb_en          (i_wb_en),
        .i_wb_tag         (i_wb_tag),
        .i_wb_data        (i_wb_data),
        .o_dispatch_tag   (o_dispatch_tag),
        .o_rob_full       (o_rob_full),
        .o_lookup_data0   (o_lookup_data0),
        .o_lookup_data1   (o_lookup_data1),
        .o_lookup_tag0    (o_lookup_tag0),
        .o_lookup_tag1    (o_lookup_tag1),
        .o_lookup_rdy0    (o_lookup_rdy0),
        .o_lookup_rdy1    (o_lookup_rdy1)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic add_row(input string name, input op_t op, input int rdest, input int tag,
                           input int src0, input int src1, input bit chk);
        row_name.push_back(name);
        row_op.push_back(op);
        row_rdest.push_back(REGMAP_IDX_WIDTH'(rdest));
        row_tag.push_back(ROB_IDX_WIDTH'(tag));
        row_data.push_back($urandom);
        row_src0.push_back(REGMAP_IDX_WIDTH'(src0));
        row_src1.push_back(REGMAP_IDX_WIDTH'(src1));
        row_check.push_back(chk);
    endtask

    task automatic build_table();
        for (int r = 0; r < REGMAP_DEPTH; r += 2) begin
            add_row("reset_state", OP_IDLE, 0, 0, r, r + 1, 1'b1);
        end

        // Tail starts at tag 0
        add_row("rename_commit", OP_DISPATCH, 5, 0, 5, 6, 1'b1);
        add_row("rename_commit", OP_IDLE, 0, 0, 5, 6, 1'b1);
        add_row("rename_commit", OP_WB, 0, 0, 5, 6, 1'b1);
        add_row("rename_commit", OP_IDLE, 0, 0, 5, 6, 1'b1);
        add_row("rename_commit", OP_IDLE, 0, 0, 5, 0, 1'b1);

        // Two renames of r7 around one of r8, results come back youngest first
        add_row("ooo_writeback", OP_DISPATCH, 7, 0, 7, 8, 1'b1);
        add_row("ooo_writeback", OP_DISPATCH, 8, 0, 7, 8, 1'b1);
        add_row("ooo_writeback", OP_DISPATCH, 7, 0, 7, 8, 1'b1);
        add_row("ooo_writeback", OP_WB, 0, 3, 7, 8, 1'b1);
        add_row("ooo_writeback", OP_WB, 0, 2, 7, 8, 1'b1);
        add_row("ooo_writeback", OP_IDLE, 0, 0, 7, 8, 1'b1);
        add_row("ooo_writeback", OP_WB, 0, 1, 7, 8, 1'b1);
        for (int i = 0; i < 4; i++) begin
            add_row("ooo_writeback", OP_IDLE, 0, 0, 7, 8, 1'b1);
        end

        add_row("reg_zero", OP_DISPATCH, 0, 0, 0, 0, 1'b1);
        add_row("reg_zero", OP_IDLE, 0, 0, 0, 5, 1'b1);
        add_row("reg_zero", OP_WB, 0, 4, 0, 7, 1'b1);
        add_row("reg_zero", OP_IDLE, 0, 0, 0, 0, 1'b1);
        add_row("reg_zero", OP_IDLE, 0, 0, 0, 8, 1'b1);

        // Second rename of r3 lands in the cycle where the first one retires
        add_row("same_cycle", OP_DISPATCH, 3, 0, 3, 0, 1'b1);
        add_row("same_cycle", OP_WB, 0, 5, 3, 0, 1'b1);
        add_row("same_cycle", OP_DISPATCH, 3, 0, 3, 0, 1'b1);
        add_row("same_cycle", OP_IDLE, 0, 0, 3, 0, 1'b1);
        add_row("same_cycle", OP_WB, 0, 6, 3, 0, 1'b1);
        add_row("same_cycle", OP_IDLE, 0, 0, 3, 0, 1'b1);
        add_row("same_cycle", OP_IDLE, 0, 0, 3, 0, 1'b1);

        for (int i = 0; i < ROB_DEPTH; i++) begin
            add_row("full_rob", OP_DISPATCH, 10 + i, 0, 10 + i, 26, i == 0 || i == ROB_DEPTH - 1);
        end
        add_row("full_rob", OP_DISPATCH, 26, 0, 26, 10, 1'b1);
        add_row("full_rob", OP_IDLE, 0, 0, 26, 25, 1'b1);

        add_row("flush", OP_FLUSH, 0, 0, 10, 5, 1'b1);
        add_row("flush", OP_IDLE, 0, 0, 10, 11, 1'b1);
        add_row("flush", OP_IDLE, 0, 0, 5, 7, 1'b1);
        add_row("flush", OP_IDLE, 0, 0, 8, 3, 1'b1);
        add_row("flush", OP_IDLE, 0, 0, 25, 26, 1'b1);
        add_row("flush", OP_DISPATCH, 12, 0, 12, 3, 1'b1);
        add_row("flush", OP_WB, 0, 0, 12, 3, 1'b1);
        add_row("flush", OP_IDLE, 0, 0, 12, 3, 1'b1);
        add_row("flush", OP_IDLE, 0, 0, 12, 3, 1'b1);
    endtask

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            test_errors++;
            $display("error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    function automatic bit retiring(input op_t op);
        return rob_tag.size() > 0 && rob_done[0] && op != OP_FLUSH;
    endfunction

    task automatic expect_lookup(input logic [REGMAP_IDX_WIDTH-1:0] src, input bit ret,
                                 output logic [DATA_WIDTH-1:0] data,
                                 output logic [ROB_IDX_WIDTH-1:0] tag, output logic rdy);
        data = m_data[src];
        tag  = m_tag[src];
        rdy  = m_rdy[src];
        // Value leaving the reorder buffer this cycle is forwarded
        if (ret && !m_rdy[src] && m_tag[src] == rob_tag[0] && rob_rdest[0] == src) begin
            data = rob_data[0];
            tag  = rob_tag[0];
            rdy  = 1'b1;
        end
    endtask

    task automatic check_row(input int k);
        logic [DATA_WIDTH-1:0]    exp_data;
        logic [ROB_IDX_WIDTH-1:0] exp_tag;
        logic                     exp_rdy;
        bit                       ret;

        ret = retiring(row_op[k]);
        compare("dispatch tag", 32'(m_tail), 32'(o_dispatch_tag));
        compare("rob full", 32'(rob_tag.size() == ROB_DEPTH), 32'(o_rob_full));

        expect_lookup(row_src0[k], ret, exp_data, exp_tag, exp_rdy);
        compare($sformatf("data r%0d", row_src0[k]), exp_data, o_lookup_data0);
        compare($sformatf("tag r%0d", row_src0[k]), 32'(exp_tag), 32'(o_lookup_tag0));
        compare($sformatf("rdy r%0d", row_src0[k]), 32'(exp_rdy), 32'(o_lookup_rdy0));

        expect_lookup(row_src1[k], ret, exp_data, exp_tag, exp_rdy);
        compare($sformatf("data r%0d", row_src1[k]), exp_data, o_lookup_data1);
        compare($sformatf("tag r%0d", row_src1[k]), 32'(exp_tag), 32'(o_lookup_tag1));
        compare($sformatf("rdy r%0d", row_src1[k]), 32'(exp_rdy), 32'(o_lookup_rdy1));
    endtask

    // Moves the model to the state after the next rising edge
    task automatic step_model(input int k);
        bit                          ret;
        bit                          accept;
        logic [REGMAP_IDX_WIDTH-1:0] rd;

        ret    = retiring(row_op[k]);
        accept = row_op[k] == OP_DISPATCH && rob_tag.size() < ROB_DEPTH;
        if (row_op[k] == OP_FLUSH) begin
            rob_tag.delete();
            rob_rdest.delete();
            rob_done.delete();
            rob_data.delete();
            m_tail = '0;
            for (int r = 0; r < REGMAP_DEPTH; r++) begin
                m_rdy[r] = 1'b1;
            end
        end else begin
            if (row_op[k] == OP_WB) begin
                for (int i = 0; i < rob_tag.size(); i++) begin
                    if (rob_tag[i] == row_tag[k]) begin
                        rob_done[i] = 1'b1;
                        rob_data[i] = row_data[k];
                    end
                end
            end
            if (ret) begin
                rd = rob_rdest[0];
                if (rd != '0) begin
                    m_data[rd] = rob_data[0];
                    if (m_tag[rd] == rob_tag[0]) begin
                        m_rdy[rd] = 1'b1;
                    end
                end
                void'(rob_tag.pop_front());
                void'(rob_rdest.pop_front());
                void'(rob_done.pop_front());
                void'(rob_data.pop_front());
            end
            // Rename comes last so it overrides a retire to the same register
            if (accept) begin
                rd = row_rdest[k];
                rob_tag.push_back(m_tail);
                rob_rdest.push_back(rd);
                rob_done.push_back(1'b0);
                rob_data.push_back('0);
                if (rd != '0) begin
                    m_tag[rd] = m_tail;
                    m_rdy[rd] = 1'b0;
                end
                m_tail = m_tail + 1'b1;
            end
        end
    endtask

    task automatic drive_row(input int k);
        i_dispatch_en    = row_op[k] == OP_DISPATCH;
        i_dispatch_rdest = row_rdest[k];
        i_wb_en          = row_op[k] == OP_WB;
        i_wb_tag         = row_tag[k];
        i_wb_data        = row_data[k];
        i_flush          = row_op[k] == OP_FLUSH;
        i_lookup_rsrc0   = row_src0[k];
        i_lookup_rsrc1   = row_src1[k];
    endtask

    task automatic report_test();
        tests_run++;
        $display("test %s: %0d rows, %0d mismatches", cur_test, test_rows, test_errors);
    endtask

    initial begin
        i_rst_n          = 1'b0;
        i_flush          = 1'b0;
        i_dispatch_en    = 1'b0;
        i_dispatch_rdest = '0;
        i_lookup_rsrc0   = '0;
        i_lookup_rsrc1   = '0;
        i_wb_en          = 1'b0;
        i_wb_tag         = '0;
        i_wb_data        = '0;

        void'($urandom(32'h22228e23));
        build_table();
        cycle_limit = row_name.size() * 4 + 100;

        for (int r = 0; r < REGMAP_DEPTH; r++) begin
            m_data[r] = '0;
            m_tag[r]  = '0;
            m_rdy[r]  = 1'b1;
        end
        m_tail = '0;

        repeat (16) @(posedge clk);
        #2;
        i_rst_n = 1'b1;

        for (int k = 0; k < row_name.size(); k++) begin
            if (row_name[k] != cur_test) begin
                if (cur_test != "") begin
                    report_test();
                end
                cur_test    = row_name[k];
                test_rows   = 0;
                test_errors = 0;
            end
            @(posedge clk);
            #2;
            drive_row(k);
            // Outputs settle well before the falling edge
            @(negedge clk);
            if (row_check[k]) begin
                check_row(k);
            end
            step_model(k);
            test_rows++;
        end
        report_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rename_core.f
verilog/rename_pkg.sv
verilog/regmap_retire_if.sv
verilog/regmap_entry.sv
verilog/regmap.sv
verilog/reorder_buffer.sv
verilog/rename_core.sv
testbench/rename_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the rename core testbench with Verilator, runs it and checks the log.
# Exits with a non-zero status when the build, the run or a check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module rename_core_tb \
    -f rename_core.f -o rename_core_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/rename_core_sim > "$LOG" 2>&1 \
    || { cat "$LOG"; echo "simulation exited with an error"; exit 1; }

cat "$LOG"

grep -q "SIMULATION FAILED" "$LOG" && { echo "failures found in $LOG"; exit 1; }

exit 0
